/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_vision
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard src/*.sv src/*.svh testbench/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* src/cam_capture.sv */
// camera byte capture
`timescale 1ns/1ps
`include "vision_consts.svh"

module cam_capture
  import vision_pkg::*;
(
  input  logic         clk_50,
  input  logic         rst_n,
  input  logic         cam_vsync,
  input  logic         cam_href,
  input  logic [7:0]   cam_data,
  fb_port_if.requester wr
);

  // low = first byte of a pixel expected
  logic                byte_phase;
  logic [3:0]          red_hold;
  pixel_t              pix_q;
  logic                req_q;
  // one extra bit so the count can sit at 128
  logic [`FB_ADDR_W:0] wr_count;
  logic                frame_full;

  // msb set once the whole frame is written
  assign frame_full = wr_count[`FB_ADDR_W];

  always_ff @(posedge clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      byte_phase <= 1'b0;
      req_q      <= 1'b0;
      wr_count   <= '0;
    end else if (cam_vsync) begin
      // new frame, restart at pixel 0
      byte_phase <= 1'b0;
      req_q      <= 1'b0;
      wr_count   <= '0;
    end else begin
      // write port always wins, so the grant comes at once
      if (wr.gnt) begin
        req_q    <= 1'b0;
        wr_count <= wr_count + 1'b1;
      end
      if (cam_href) begin
        byte_phase <= ~byte_phase;
        // second byte done, request unless frame already full
        if (byte_phase && !frame_full) begin
          req_q <= 1'b1;
        end
      end else begin
        byte_phase <= 1'b0;
      end
    end
  end

  // pixel assembly
  always_ff @(posedge clk_50) begin
    if (cam_href && !byte_phase) begin
      red_hold <= cam_data[3:0];
    end
    if (cam_href && byte_phase) begin
      pix_q <= {red_hold, cam_data};
    end
  end

  assign wr.req   = req_q;
  assign wr.we    = 1'b1;
  assign wr.addr  = wr_count[`FB_ADDR_W-1:0];
  assign wr.wdata = pix_q;

  // writes leave every other cycle free for the reader
  a_req_spacing: assert property (@(posedge clk_50) disable iff (!rst_n)
    wr.req |=> !wr.req);

endmodule

/* src/fb_port_if.sv */
// frame buffer port bundle
`timescale 1ns/1ps
`include "vision_consts.svh"

interface fb_port_if
  import vision_pkg::*;
();

  // requester side
  logic                  req;
  logic                  we;
  logic [`FB_ADDR_W-1:0] addr;
  pixel_t                wdata;

  // arbiter side
  // rdata valid the cycle after gnt
  logic                  gnt;
  pixel_t                rdata;

  modport requester (output req, we, addr, wdata, input gnt, rdata);
  modport arbiter (input req, we, addr, wdata, output gnt, rdata);

endinterface

/* src/frame_buffer.sv */
// frame buffer with port arbiter
`timescale 1ns/1ps
`include "vision_consts.svh"

module frame_buffer
  import vision_pkg::*;
(
  input  logic        clk_50,
  input  logic        rst_n,
  fb_port_if.arbiter  wr,
  fb_port_if.arbiter  rd
);

  // one word per pixel
  pixel_t mem [0:`FRAME_W*`FRAME_H-1];
  pixel_t rd_q;
  logic   do_write;
  logic   do_read;

  // fixed priority
  // camera cannot stall, so writes always win
  assign wr.gnt = wr.req;
  assign rd.gnt = rd.req && !wr.req;

  assign do_write = wr.gnt && wr.we;
  assign do_read  = rd.gnt && !rd.we;

  // single port with at most one access per cycle
  always_ff @(posedge clk_50) begin
    if (do_write) begin
      mem[wr.addr] <= wr.wdata;
    end else if (do_read) begin
      rd_q <= mem[rd.addr];
    end
  end

  // read data lands the cycle after the grant
  assign rd.rdata = rd_q;
  // write requester has no read path
  assign wr.rdata = '0;

  // a blocked read waits at most one cycle behind a write
  a_read_wait: assert property (@(posedge clk_50) disable iff (!rst_n)
    (rd.req && !rd.gnt) |=> rd.gnt);

endmodule

/* src/scan_reader.sv */
// raster scan reader
`timescale 1ns/1ps
`include "vision_consts.svh"

module scan_reader
  import vision_pkg::*;
(
  input  logic         clk_50,
  input  logic         rst_n,
  input  logic         scan_start,
  fb_port_if.requester rd,
  output logic         scan_pixel_valid,
  output pixel_t       scan_pixel
);

  logic                  busy;
  logic [`FB_ADDR_W-1:0] rd_addr;
  logic                  gnt_d;
  logic                  last_addr;

  // pixel 127 ends the scan
  assign last_addr = (rd_addr == '1);

  always_ff @(posedge clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      rd_addr <= '0;
      gnt_d   <= 1'b0;
    end else begin
      gnt_d <= rd.gnt;
      if (!busy) begin
        // start only when idle
        if (scan_start) begin
          busy    <= 1'b1;
          rd_addr <= '0;
        end
      end else if (rd.gnt) begin
        // step after each granted read and wrap to 0 on the last
        rd_addr <= rd_addr + 1'b1;
        if (last_addr) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // request held while busy, address only moves on grant
  assign rd.req   = busy;
  assign rd.we    = 1'b0;
  assign rd.addr  = rd_addr;
  assign rd.wdata = '0;

  // registered word from the buffer marked by the delayed grant
  assign scan_pixel_valid = gnt_d;
  assign scan_pixel       = rd.rdata;

  a_addr_hold: assert property (@(posedge clk_50) disable iff (!rst_n)
    (rd.req && !rd.gnt) |=> (rd.req && $stable(rd.addr)));

endmodule

/* src/steer_fsm.sv */
// steering decision fsm
`timescale 1ns/1ps
`include "vision_consts.svh"

module steer_fsm
  import vision_pkg::*;
(
  input  logic       clk_50,
  input  logic       rst_n,
  input  logic       pixel_valid,
  input  logic       pixel_orange,
  input  logic [3:0] hit_column,
  output dir_e       direction,
  output logic       target_found
);

  steer_state_e        state;
  logic [`FB_ADDR_W:0] pix_cnt;
  logic [`FB_ADDR_W:0] left_cnt;
  logic [`FB_ADDR_W:0] centre_cnt;
  logic [`FB_ADDR_W:0] right_cnt;
  logic [`FB_ADDR_W:0] left_n;
  logic [`FB_ADDR_W:0] centre_n;
  logic [`FB_ADDR_W:0] right_n;
  logic [`FB_ADDR_W:0] total_n;
  logic                in_left;
  logic                in_right;
  logic                last_pix;
  logic                found_n;
  dir_e                dir_n;

  // region of the current pixel
  assign in_left  = (hit_column < `LEFT_END);
  assign in_right = (hit_column >= `RIGHT_START);

  // counts including the pixel now on the input
  always_comb begin
    left_n   = left_cnt + (pixel_orange && in_left);
    right_n  = right_cnt + (pixel_orange && in_right);
    centre_n = centre_cnt + (pixel_orange && !in_left && !in_right);
    total_n  = left_n + centre_n + right_n;
    last_pix = (state == ST_COUNT) && pixel_valid && (pix_cnt == `FB_DEPTH - 1);
    found_n  = (total_n >= `MIN_HITS);
    // strictly largest region wins and ties go to centre
    if (!found_n) begin
      dir_n = DIR_NONE;
    end else if (left_n > centre_n && left_n > right_n) begin
      dir_n = DIR_LEFT;
    end else if (right_n > centre_n && right_n > left_n) begin
      dir_n = DIR_RIGHT;
    end else begin
      dir_n = DIR_CENTRE;
    end
  end

  always_ff @(posedge clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      state        <= ST_IDLE;
      pix_cnt      <= '0;
      left_cnt     <= '0;
      centre_cnt   <= '0;
      right_cnt    <= '0;
      direction    <= DIR_NONE;
      target_found <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          // first pixel of a frame with counters already clear
          if (pixel_valid) begin
            state      <= ST_COUNT;
            pix_cnt    <= pix_cnt + 1'b1;
            left_cnt   <= left_n;
            centre_cnt <= centre_n;
            right_cnt  <= right_n;
          end
        end
        ST_COUNT: begin
          if (pixel_valid) begin
            pix_cnt    <= pix_cnt + 1'b1;
            left_cnt   <= left_n;
            centre_cnt <= centre_n;
            right_cnt  <= right_n;
          end
          // decision latched with the 128th pixel and held until next frame
          if (last_pix) begin
            state        <= ST_DECIDE;
            direction    <= dir_n;
            target_found <= found_n;
          end
        end
        ST_DECIDE: begin
          // clear counters for the next frame
          state      <= ST_IDLE;
          pix_cnt    <= '0;
          left_cnt   <= '0;
          centre_cnt <= '0;
          right_cnt  <= '0;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  a_pix_bound: assert property (@(posedge clk_50) disable iff (!rst_n)
    pix_cnt <= `FB_DEPTH);

endmodule

/* src/target_finder.sv */
// orange pixel classifier
`timescale 1ns/1ps
`include "vision_consts.svh"

module target_finder
  import vision_pkg::*;
(
  input  logic       clk_50,
  input  logic       rst_n,
  input  logic       scan_pixel_valid,
  input  pixel_t     scan_pixel,
  output logic       pixel_valid,
  output pixel_t     pixel_rgb,
  output logic       pixel_orange,
  output logic [3:0] hit_column
);

  logic [3:0] col_cnt;
  logic       line_end;
  logic       is_orange;

  // red high, green mid, blue low
  assign is_orange = (scan_pixel[11:8] >= `ORANGE_R_MIN) &&
                     (scan_pixel[7:4] >= `ORANGE_G_MIN) &&
                     (scan_pixel[7:4] <= `ORANGE_G_MAX) &&
                     (scan_pixel[3:0] <= `ORANGE_B_MAX);

  // last column of a line
  assign line_end = (col_cnt == 4'(`FRAME_W - 1));

  always_ff @(posedge clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      pixel_valid  <= 1'b0;
      pixel_orange <= 1'b0;
      hit_column   <= '0;
      col_cnt      <= '0;
    end else begin
      pixel_valid  <= scan_pixel_valid;
      pixel_orange <= scan_pixel_valid && is_orange;
      if (scan_pixel_valid) begin
        // column travels alongside the registered pixel
        hit_column <= col_cnt;
        // 128 pixels is a whole number of lines, so it ends back at 0
        col_cnt    <= line_end ? 4'd0 : col_cnt + 4'd1;
      end
    end
  end

  always_ff @(posedge clk_50) begin
    if (scan_pixel_valid) begin
      pixel_rgb <= scan_pixel;
    end
  end

endmodule

/* src/vision_consts.svh */
// vision subsystem constants
`ifndef VISION_CONSTS_SVH
`define VISION_CONSTS_SVH

// frame geometry
// 16 x 8 pixels in raster order
`define FRAME_W 16
`define FRAME_H 8
`define FB_ADDR_W 7
`define FB_DEPTH 128

// orange window on the 4-bit channels
`define ORANGE_R_MIN 12
`define ORANGE_G_MIN 4
`define ORANGE_G_MAX 9
`define ORANGE_B_MAX 4

// column regions
// left below LEFT_END, right from RIGHT_START up
`define LEFT_END 6
`define RIGHT_START 10

// fewest orange pixels that count as a target
`define MIN_HITS 4

`endif

/* src/vision_pkg.sv */
// vision shared types
package vision_pkg;

  // rgb444 word
  // red [11:8], green [7:4], blue [3:0]
  typedef logic [11:0] pixel_t;

  // steering decision
  typedef enum logic [1:0] {
    DIR_NONE   = 2'd0,
    DIR_LEFT   = 2'd1,
    DIR_CENTRE = 2'd2,
    DIR_RIGHT  = 2'd3
  } dir_e;

  // steering fsm states
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_COUNT  = 2'd1,
    ST_DECIDE = 2'd2
  } steer_state_e;

endpackage

/* src/vision_top.sv */
// camera vision top level
`timescale 1ns/1ps

module vision_top
  import vision_pkg::*;
(
  input  logic       clk_50,
  input  logic       rst_n,
  input  logic       cam_vsync,
  input  logic       cam_href,
  input  logic [7:0] cam_data,
  input  logic       scan_start,
  output logic       pixel_valid,
  output pixel_t     pixel_rgb,
  output logic       pixel_orange,
  output dir_e       direction,
  output logic       target_found
);

  // reader to classifier
  logic       scan_pixel_valid;
  pixel_t     scan_pixel;
  // classifier to fsm
  logic [3:0] hit_column;

  // two requesters on the single buffer port
  fb_port_if wr_port ();
  fb_port_if rd_port ();

  cam_capture u_cam_capture (
    .clk_50    (clk_50),
    .rst_n     (rst_n),
    .cam_vsync (cam_vsync),
    .cam_href  (cam_href),
    .cam_data  (cam_data),
    .wr        (wr_port.requester)
  );

  frame_buffer u_frame_buffer (
    .clk_50 (clk_50),
    .rst_n  (rst_n),
    .wr     (wr_port.arbiter),
    .rd     (rd_port.arbiter)
  );

  scan_reader u_scan_reader (
    .clk_50           (clk_50),
    .rst_n            (rst_n),
    .scan_start       (scan_start),
    .rd               (rd_port.requester),
    .scan_pixel_valid (scan_pixel_valid),
    .scan_pixel       (scan_pixel)
  );

  target_finder u_target_finder (
    .clk_50           (clk_50),
    .rst_n            (rst_n),
    .scan_pixel_valid (scan_pixel_valid),
    .scan_pixel       (scan_pixel),
    .pixel_valid      (pixel_valid),
    .pixel_rgb        (pixel_rgb),
    .pixel_orange     (pixel_orange),
    .hit_column       (hit_column)
  );

  steer_fsm u_steer_fsm (
    .clk_50       (clk_50),
    .rst_n        (rst_n),
    .pixel_valid  (pixel_valid),
    .pixel_orange (pixel_orange),
    .hit_column   (hit_column),
    .direction    (direction),
    .target_found (target_found)
  );

endmodule

/* tb.f */
+incdir+src
src/vision_pkg.sv
src/fb_port_if.sv
src/cam_capture.sv
src/frame_buffer.sv
src/scan_reader.sv
src/target_finder.sv
src/steer_fsm.sv
src/vision_top.sv
testbench/tb_vision.sv

/* testbench/tb_vision.sv */
// vision subsystem testbench
`timescale 1ns/1ps
`include "vision_consts.svh"

module tb_vision
  import vision_pkg::*;
();

  // about 4 frames of 260 capture plus 140 scan cycles doubled with margin
  localparam int          CYCLE_LIMIT = 4000;
  localparam logic [31:0] LFSR_SEED   = 32'hdc05_25b1;
  localparam logic [31:0] LFSR_MASK   = 32'h8020_0003;
  // r 15, g 6, b 0
  localparam pixel_t      ORANGE_PX   = 12'hf60;

  logic       clk_50;
  logic       rst_n;
  logic       cam_vsync;
  logic       cam_href;
  logic [7:0] cam_data;
  logic       scan_start;
  logic       pixel_valid;
  pixel_t     pixel_rgb;
  logic       pixel_orange;
  dir_e       direction;
  logic       target_found;

  // expected frame in raster order
  pixel_t      frame_mem [0:`FB_DEPTH-1];
  logic [31:0] lfsr;
  int          pix_seen;
  int          cycle_cnt = 0;

  vision_top UUT (
    .clk_50       (clk_50),
    .rst_n        (rst_n),
    .cam_vsync    (cam_vsync),
    .cam_href     (cam_href),
    .cam_data     (cam_data),
    .scan_start   (scan_start),
    .pixel_valid  (pixel_valid),
    .pixel_rgb    (pixel_rgb),
    .pixel_orange (pixel_orange),
    .direction    (direction),
    .target_found (target_found)
  );

  initial begin
    clk_50 = 1'b0;
    forever #50 clk_50 = ~clk_50;
  end

  task automatic fail_value(input string msg);
    $display("[FAIL] %0t %s", $time, msg);
    $display("Something failed");
    $fatal(1, "wrong value");
  endtask

  // galois lfsr stepped once per bit taken
  function automatic logic [11:0] rand_bits(input int n);
    logic [11:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v    = {v[10:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_MASK : 32'h0);
    end
    return v;
  endfunction

  // threshold window on the 4-bit channels
  function automatic logic orange_ref(input pixel_t p);
    return (p[11:8] >= `ORANGE_R_MIN) && (p[7:4] >= `ORANGE_G_MIN) &&
           (p[7:4] <= `ORANGE_G_MAX) && (p[3:0] <= `ORANGE_B_MAX);
  endfunction

  // random background and then a column of orange pixels from row 0 down
  task automatic build_frame(input int col, input int hits);
    pixel_t px;
    int     i;
    for (i = 0; i < `FB_DEPTH; i++) begin
      px = rand_bits(12);
      // keep stray orange out of the background
      if (orange_ref(px))
        px[3:0] = 4'hf;
      frame_mem[i] = px;
    end
    for (i = 0; i < hits; i++)
      frame_mem[i * `FRAME_W + col] = ORANGE_PX;
  endtask

  // region rule on the model frame
  task automatic expected_decision(output dir_e d, output logic found);
    int i;
    int col;
    int n_left;
    int n_centre;
    int n_right;
    n_left   = 0;
    n_centre = 0;
    n_right  = 0;
    for (i = 0; i < `FB_DEPTH; i++) begin
      col = i % `FRAME_W;
      if (orange_ref(frame_mem[i])) begin
        if (col < `LEFT_END)
          n_left++;
        else if (col >= `RIGHT_START)
          n_right++;
        else
          n_centre++;
      end
    end
    found = (n_left + n_centre + n_right) >= `MIN_HITS;
    if (!found)
      d = DIR_NONE;
    else if (n_left > n_centre && n_left > n_right)
      d = DIR_LEFT;
    else if (n_right > n_centre && n_right > n_left)
      d = DIR_RIGHT;
    else
      d = DIR_CENTRE;
  endtask

  // vsync pulse then two bytes per pixel with href held high
  task automatic send_frame();
    logic [11:0] junk;
    int          i;
    cam_vsync = 1'b1;
    @(negedge clk_50);
    cam_vsync = 1'b0;
    cam_href  = 1'b1;
    for (i = 0; i < `FB_DEPTH; i++) begin
      // high nibble of the first byte is don't care
      junk     = rand_bits(4);
      cam_data = {junk[3:0], frame_mem[i][11:8]};
      @(negedge clk_50);
      cam_data = frame_mem[i][7:0];
      @(negedge clk_50);
    end
    cam_href = 1'b0;
    cam_data = 8'h00;
    repeat (4) @(negedge clk_50);
  endtask

  // decision lands one cycle after the 128th pixel
  task automatic scan_and_check(input string tag);
    dir_e exp_dir;
    logic exp_found;
    expected_decision(exp_dir, exp_found);
    pix_seen   = 0;
    scan_start = 1'b1;
    @(negedge clk_50);
    scan_start = 1'b0;
    wait (pix_seen == `FB_DEPTH);
    @(negedge clk_50);
    assert (direction == exp_dir && target_found == exp_found)
      else fail_value($sformatf("%s dir %0d found %0b expected dir %0d found %0b",
                                tag, direction, target_found, exp_dir, exp_found));
    // window for a stray pixel past the end of the scan
    repeat (4) @(negedge clk_50);
  endtask

  // pixel stream checked against the model mid cycle
  always @(negedge clk_50) begin
    if (rst_n && pixel_valid) begin
      assert (pix_seen < `FB_DEPTH)
        else fail_value("more than 128 pixels in one scan");
      assert (pixel_rgb == frame_mem[pix_seen])
        else fail_value($sformatf("pixel %0d rgb %03h expected %03h",
                                  pix_seen, pixel_rgb, frame_mem[pix_seen]));
      assert (pixel_orange == orange_ref(frame_mem[pix_seen]))
        else fail_value($sformatf("pixel %0d orange flag %0b", pix_seen, pixel_orange));
      pix_seen = pix_seen + 1;
    end
  end

  a_orange_valid: assert property (@(posedge clk_50) disable iff (!rst_n)
    pixel_orange |-> pixel_valid)
    else fail_value("pixel_orange without pixel_valid");

  // decision only moves right after a frame's last pixel
  a_decision_hold: assert property (@(posedge clk_50) disable iff (!rst_n)
    (!$stable(direction) || !$stable(target_found)) |-> $past(pixel_valid))
    else fail_value("decision changed outside a frame end");

  always @(posedge clk_50) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("simulation did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Something failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst_n      = 1'b0;
    cam_vsync  = 1'b0;
    cam_href   = 1'b0;
    cam_data   = 8'h00;
    scan_start = 1'b0;
    lfsr       = LFSR_SEED;
    pix_seen   = 0;
    repeat (16) @(negedge clk_50);
    rst_n = 1'b1;
    @(negedge clk_50);
    assert (!pixel_valid && !target_found && direction == DIR_NONE)
      else fail_value("outputs not idle after reset");
    // target mostly left, then right, then too few hits
    build_frame(2, 8);
    send_frame();
    scan_and_check("left frame");
    build_frame(13, 8);
    send_frame();
    scan_and_check("right frame");
    build_frame(7, 3);
    send_frame();
    scan_and_check("sparse frame");
    // same frame again while the reader shares the port
    fork
      send_frame();
      begin
        repeat (6) @(negedge clk_50);
        scan_and_check("scan during capture");
      end
    join
    $display("Everything OK");
    $finish;
  end

endmodule
